//--- tb.f
+incdir+verif
common/lpc_pkg.sv
levinson/coef_bank.sv
levinson/recursion_fsm.sv
hdl/lpc_datapath.sv
hdl/fixed_div.sv
hdl/levinson_top.sv
verif/levinson_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the Levinson testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module levinson_tb \
	-o levinson_sim > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/levinson_sim > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0

//--- verif/lpc_model.svh
// Levinson recursion reference model
`ifndef LPC_MODEL_SVH
`define LPC_MODEL_SVH

// full signed product, back to FRAC_BITS fraction bits, low FIX_WIDTH bits kept
function automatic lpc_pkg::fix_t fix_mul(input lpc_pkg::fix_t a, input lpc_pkg::fix_t b);
	logic signed [2*lpc_pkg::FIX_WIDTH-1:0] wide_a;
	logic signed [2*lpc_pkg::FIX_WIDTH-1:0] wide_b;
	logic signed [2*lpc_pkg::FIX_WIDTH-1:0] prod;
	wide_a = a;
	wide_b = b;
	prod = wide_a * wide_b;
	prod = prod >>> lpc_pkg::FRAC_BITS;
	return prod[lpc_pkg::FIX_WIDTH-1:0];
endfunction

// quotient of num * 2^FRAC_BITS by den, on magnitudes, truncated toward zero
function automatic lpc_pkg::fix_t fix_div(input lpc_pkg::fix_t num, input lpc_pkg::fix_t den);
	logic [lpc_pkg::FIX_WIDTH-1:0] num_mag;
	logic [lpc_pkg::FIX_WIDTH-1:0] den_mag;
	logic [lpc_pkg::DIV_WIDTH-1:0] scaled;
	logic [lpc_pkg::DIV_WIDTH-1:0] divisor;
	logic [lpc_pkg::DIV_WIDTH-1:0] q_mag;
	lpc_pkg::fix_t q;
	num_mag = num[lpc_pkg::FIX_WIDTH-1] ? -num : num;
	den_mag = den[lpc_pkg::FIX_WIDTH-1] ? -den : den;
	scaled = num_mag;
	scaled = scaled << lpc_pkg::FRAC_BITS;
	divisor = den_mag;
	q_mag = scaled / divisor;
	q = q_mag[lpc_pkg::FIX_WIDTH-1:0];
	if (num[lpc_pkg::FIX_WIDTH-1] ^ den[lpc_pkg::FIX_WIDTH-1])
		q = -q;
	return q;
endfunction

// the eleven output words for one frame, element n is word n
function automatic lpc_pkg::autocorr_t predict_coefs(input lpc_pkg::autocorr_t r);
	lpc_pkg::fix_t a_old [0:lpc_pkg::ORDER];
	lpc_pkg::fix_t a_new [0:lpc_pkg::ORDER];
	lpc_pkg::fix_t err;
	lpc_pkg::fix_t sum;
	lpc_pkg::fix_t lag_val;
	lpc_pkg::fix_t k;
	lpc_pkg::autocorr_t coefs;
	for (int n = 0; n <= lpc_pkg::ORDER; n++)
	begin
		a_old[n] = '0;
		a_new[n] = '0;
	end
	err = r[0];
	for (int i = 1; i <= lpc_pkg::ORDER; i++)
	begin
		lag_val = r[i];
		sum = lag_val;
		for (int j = 1; j < i; j++)
		begin
			lag_val = r[i-j];
			sum = sum + fix_mul(a_old[j], lag_val);
		end
		k = -fix_div(sum, err);
		// clamp, an unstable k is dropped
		if (k >= lpc_pkg::FIX_ONE || k <= -lpc_pkg::FIX_ONE)
			k = '0;
		a_new[i] = k;
		for (int j = 1; j < i; j++)
			a_new[j] = a_old[j] + fix_mul(k, a_old[i-j]);
		err = fix_mul(err, lpc_pkg::FIX_ONE - fix_mul(k, k));
		a_old = a_new;
	end
	coefs[0] = lpc_pkg::FIX_ONE;
	for (int n = 1; n <= lpc_pkg::ORDER; n++)
		coefs[n] = a_old[n];
	return coefs;
endfunction

`endif

//--- verif/levinson_tb.sv
// Levinson engine testbench
`timescale 1ns/100ps
`default_nettype none

module levinson_tb;

	// R0 is 16384.0 and the other lags stay below a quarter of it
	localparam lpc_pkg::fix_t BIG_R0 = lpc_pkg::fix_t'(34'h0_4000_0000);
	localparam int unsigned LAG_LIMIT = 32'h1000_0000;
	localparam int FRAME_TIMEOUT = 2000;
	localparam int RANDOM_FRAMES = 5;

	logic clk = 1'b0;
	logic rst;
	logic start;
	lpc_pkg::autocorr_t autocorr;
	lpc_pkg::lpc_word_t lpc_out;
	logic done;

	`include "lpc_model.svh"

	levinson_top levinson_top_inst
	(
		.clk(clk),
		.rst(rst),
		.start(start),
		.autocorr(autocorr),
		.lpc_out(lpc_out),
		.done(done)
	);

	always #5 clk = ~clk;

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Verification failed");
		$fatal(1);
	endtask

	// outputs are settled and inputs are driven 1 ns after the edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic check_idle(input int cycles, input string name);
		for (int n = 0; n < cycles; n++)
		begin
			step();
			assert (!done && !lpc_out.we)
			else fail_run($sformatf("done or strobe seen while idle in %s", name));
		end
	endtask

	function automatic lpc_pkg::autocorr_t random_frame();
		lpc_pkg::autocorr_t r;
		lpc_pkg::fix_t mag;
		r[0] = BIG_R0;
		for (int n = 1; n <= lpc_pkg::ORDER; n++)
		begin
			mag = lpc_pkg::fix_t'($urandom % LAG_LIMIT);
			r[n] = ($urandom % 2 == 1) ? -mag : mag;
		end
		return r;
	endfunction

	// runs one frame and checks every strobe
	// start pulses again right after restart_after words, never when it is -1
	task automatic run_frame(input string name, input lpc_pkg::autocorr_t r,
		input lpc_pkg::autocorr_t want, input int restart_after);
		int cycles;
		int words;
		int gap;
		bit done_seen;
		cycles = 0;
		words = 0;
		gap = 2;
		done_seen = 1'b0;
		autocorr = r;
		start = 1'b1;
		step();
		start = 1'b0;
		while (!done_seen)
		begin
			if (lpc_out.we)
			begin
				assert (words <= lpc_pkg::ORDER)
				else fail_run($sformatf("%s: more than eleven strobes", name));
				assert (gap >= 2)
				else fail_run($sformatf("%s: strobes on back to back cycles", name));
				assert (lpc_out.addr == words)
				else fail_run($sformatf("MISMATCH %s addr expected %0d actual %0d",
					name, words, lpc_out.addr));
				assert (lpc_out.value == want[words])
				else fail_run($sformatf("MISMATCH %s word %0d expected %h actual %h",
					name, words, want[words], lpc_out.value));
				words++;
				gap = 0;
			end
			if (done)
			begin
				assert (words == lpc_pkg::ORDER + 1)
				else fail_run($sformatf("%s: done after %0d strobes", name, words));
				assert (gap == 1)
				else fail_run($sformatf("%s: done not one cycle after last strobe", name));
				done_seen = 1'b1;
			end
			else
			begin
				assert (cycles < FRAME_TIMEOUT)
				else fail_run($sformatf("%s: timed out waiting for done", name));
				start = (gap == 0 && words == restart_after);
				step();
				cycles++;
				gap++;
			end
		end
		start = 1'b0;
	endtask

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------

	initial
	begin
		lpc_pkg::autocorr_t frame;
		lpc_pkg::autocorr_t want;
		rst = 1'b0;
		start = 1'b0;
		autocorr = '0;
		void'($urandom(32'he922_173c));

		repeat (4)
		begin
			step();
			assert (!done && !lpc_out.we)
			else fail_run("done or strobe active during reset");
		end
		rst = 1'b1;
		check_idle(10, "after reset");

		// with no correlation beyond lag 0 the predictor is 1.0 and zeros
		frame = '0;
		frame[0] = BIG_R0;
		want = '0;
		want[0] = lpc_pkg::FIX_ONE;
		run_frame("zero_lags", frame, want, -1);
		check_idle(5, "zero_lags");

		for (int n = 0; n < RANDOM_FRAMES; n++)
		begin
			frame = random_frame();
			run_frame($sformatf("random_%0d", n), frame, predict_coefs(frame), -1);
			check_idle(5, "random");
		end

		// R1 equal to R0 gives k of -1.0 at order 1
		frame = random_frame();
		frame[1] = frame[0];
		run_frame("clamp", frame, predict_coefs(frame), -1);
		check_idle(5, "clamp");

		// second start in the middle of the output stream
		frame = random_frame();
		run_frame("restart_busy", frame, predict_coefs(frame), 5);
		check_idle(FRAME_TIMEOUT, "restart_busy");
		frame = random_frame();
		run_frame("after_restart", frame, predict_coefs(frame), -1);
		check_idle(5, "after_restart");

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/levinson_top.sv
// Levinson-Durbin engine top level
`timescale 1ns/100ps
`default_nettype none

module levinson_top
(
	input logic clk,
	input logic rst,
	input logic start,
	input lpc_pkg::autocorr_t autocorr,
	output lpc_pkg::lpc_word_t lpc_out,
	output logic done
);

	// coefficient bank access
	lpc_pkg::idx_t rd_a;
	lpc_pkg::idx_t rd_b;
	lpc_pkg::fix_t rd_a_val;
	lpc_pkg::fix_t rd_b_val;
	logic wr_en;
	lpc_pkg::idx_t wr_idx;
	lpc_pkg::fix_t wr_data;
	logic swap;
	logic clear;

	// datapath
	lpc_pkg::dp_cmd_t dp_cmd;
	lpc_pkg::fix_t acc;
	lpc_pkg::fix_t k;
	lpc_pkg::fix_t err;
	lpc_pkg::fix_t mac_result;

	// divider
	logic div_start;
	lpc_pkg::fix_t div_num;
	lpc_pkg::fix_t div_den;
	lpc_pkg::fix_t quotient;
	logic div_done;

	recursion_fsm recursion_fsm_inst
	(
		.clk(clk),
		.rst(rst),
		.start(start),
		.autocorr(autocorr),
		.rd_a_val(rd_a_val),
		.rd_b_val(rd_b_val),
		.acc(acc),
		.k(k),
		.err(err),
		.mac_result(mac_result),
		.quotient(quotient),
		.div_done(div_done),
		.rd_a(rd_a),
		.rd_b(rd_b),
		.wr_en(wr_en),
		.wr_idx(wr_idx),
		.wr_data(wr_data),
		.swap(swap),
		.clear(clear),
		.dp_cmd(dp_cmd),
		.div_start(div_start),
		.div_num(div_num),
		.div_den(div_den),
		.lpc_out(lpc_out),
		.done(done)
	);

	coef_bank coef_bank_inst
	(
		.clk(clk),
		.rst(rst),
		.clear(clear),
		.swap(swap),
		.wr_en(wr_en),
		.wr_idx(wr_idx),
		.wr_data(wr_data),
		.rd_a(rd_a),
		.rd_b(rd_b),
		.rd_a_val(rd_a_val),
		.rd_b_val(rd_b_val)
	);

	lpc_datapath lpc_datapath_inst
	(
		.clk(clk),
		.rst(rst),
		.dp_cmd(dp_cmd),
		.acc(acc),
		.k(k),
		.err(err),
		.mac_result(mac_result)
	);

	fixed_div fixed_div_inst
	(
		.clk(clk),
		.rst(rst),
		.start(div_start),
		.num(div_num),
		.den(div_den),
		.quotient(quotient),
		.done(div_done)
	);

endmodule

`default_nettype wire

//--- hdl/fixed_div.sv
// Sequential fixed-point divider
`timescale 1ns/100ps
`default_nettype none

module fixed_div
(
	input logic clk,
	input logic rst,
	input logic start,
	input lpc_pkg::fix_t num,
	input lpc_pkg::fix_t den,
	output lpc_pkg::fix_t quotient,
	output logic done
);

	logic busy;
	logic load;
	logic neg;
	logic [$clog2(lpc_pkg::DIV_WIDTH)-1:0] cnt;
	logic [lpc_pkg::FIX_WIDTH-1:0] num_mag;
	logic [lpc_pkg::FIX_WIDTH-1:0] den_mag;
	logic [lpc_pkg::DIV_WIDTH-1:0] rem;
	logic [lpc_pkg::DIV_WIDTH-1:0] quo;
	logic [lpc_pkg::DIV_WIDTH-1:0] dvs;
	logic [lpc_pkg::DIV_WIDTH-1:0] cur_rem;
	logic [lpc_pkg::DIV_WIDTH-1:0] cur_quo;
	logic [lpc_pkg::DIV_WIDTH-1:0] cur_dvs;
	logic [lpc_pkg::DIV_WIDTH-1:0] nxt_rem;
	logic [lpc_pkg::DIV_WIDTH-1:0] nxt_quo;
	logic [lpc_pkg::DIV_WIDTH:0] shifted;
	logic [lpc_pkg::DIV_WIDTH:0] diff;

	assign load = start && !busy;
	assign num_mag = num[lpc_pkg::FIX_WIDTH-1] ? -num : num;
	assign den_mag = den[lpc_pkg::FIX_WIDTH-1] ? -den : den;

	// one restoring step, the first one already on the load edge
	always_comb
	begin
		if (load)
		begin
			cur_rem = '0;
			cur_quo = {num_mag, {lpc_pkg::FRAC_BITS{1'b0}}};
			cur_dvs = {{(lpc_pkg::DIV_WIDTH-lpc_pkg::FIX_WIDTH){1'b0}}, den_mag};
		end
		else
		begin
			cur_rem = rem;
			cur_quo = quo;
			cur_dvs = dvs;
		end
		shifted = {cur_rem, cur_quo[lpc_pkg::DIV_WIDTH-1]};
		diff = shifted - {1'b0, cur_dvs};
		if (shifted >= {1'b0, cur_dvs})
		begin
			nxt_rem = diff[lpc_pkg::DIV_WIDTH-1:0];
			nxt_quo = {cur_quo[lpc_pkg::DIV_WIDTH-2:0], 1'b1};
		end
		else
		begin
			nxt_rem = shifted[lpc_pkg::DIV_WIDTH-1:0];
			nxt_quo = {cur_quo[lpc_pkg::DIV_WIDTH-2:0], 1'b0};
		end
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			busy <= 1'b0;
			done <= 1'b0;
			neg <= 1'b0;
			cnt <= '0;
			rem <= '0;
			quo <= '0;
			dvs <= '0;
			quotient <= '0;
		end
		else
		begin
			done <= 1'b0;
			if (load)
			begin
				busy <= 1'b1;
				cnt <= '0;
				neg <= num[lpc_pkg::FIX_WIDTH-1] ^ den[lpc_pkg::FIX_WIDTH-1];
				rem <= nxt_rem;
				quo <= nxt_quo;
				dvs <= cur_dvs;
			end
			else if (busy)
			begin
				rem <= nxt_rem;
				quo <= nxt_quo;
				cnt <= cnt + 1'b1;
				// last quotient bit, sign applied to the truncated magnitude
				if (int'(cnt) == lpc_pkg::DIV_WIDTH - 2)
				begin
					busy <= 1'b0;
					done <= 1'b1;
					quotient <= neg ? -lpc_pkg::fix_t'(nxt_quo) : lpc_pkg::fix_t'(nxt_quo);
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/lpc_datapath.sv
// Shared multiply-add datapath
`timescale 1ns/100ps
`default_nettype none

module lpc_datapath
(
	input logic clk,
	input logic rst,
	input lpc_pkg::dp_cmd_t dp_cmd,
	output lpc_pkg::fix_t acc,
	output lpc_pkg::fix_t k,
	output lpc_pkg::fix_t err,
	output lpc_pkg::fix_t mac_result
);

	lpc_pkg::fix_t mul_a;
	lpc_pkg::fix_t mul_b;
	lpc_pkg::fix_t product;
	lpc_pkg::fix_t add_a;
	lpc_pkg::fix_t sum;
	lpc_pkg::fix_t one_minus_kk;
	lpc_pkg::fix_t neg_lhs;
	lpc_pkg::fix_t k_next;
	logic signed [2*lpc_pkg::FIX_WIDTH-1:0] prod_full;

	// ------------------------------------------------------------------------
	// operand select for the single multiplier and adder
	// ------------------------------------------------------------------------

	// acc holds k * k when the error update is issued
	assign one_minus_kk = lpc_pkg::FIX_ONE - acc;

	always_comb
	begin
		mul_a = dp_cmd.rhs;
		mul_b = k;
		add_a = dp_cmd.lhs;
		case (dp_cmd.op)
			lpc_pkg::DP_ACC:
			begin
				mul_a = dp_cmd.lhs;
				mul_b = dp_cmd.rhs;
				add_a = acc;
			end
			lpc_pkg::DP_UPD_ERR:
			begin
				mul_a = err;
				mul_b = one_minus_kk;
			end
			default:
			begin
			end
		endcase
	end

	// full product, back to 16 fraction bits, truncated
	assign prod_full = mul_a * mul_b;
	assign product = lpc_pkg::fix_t'(prod_full >>> lpc_pkg::FRAC_BITS);
	assign sum = add_a + product;

	// lhs + rhs * k during a coefficient update
	assign mac_result = sum;

	// reflection coefficient, forced to zero at |k| >= 1.0
	assign neg_lhs = -dp_cmd.lhs;
	assign k_next = (neg_lhs >= lpc_pkg::FIX_ONE || neg_lhs <= -lpc_pkg::FIX_ONE) ? '0 : neg_lhs;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			acc <= '0;
			k <= '0;
			err <= '0;
		end
		else
		begin
			case (dp_cmd.op)
				lpc_pkg::DP_CLEAR:
				begin
					acc <= '0;
					err <= dp_cmd.lhs;
				end
				lpc_pkg::DP_ACC:
					acc <= sum;
				lpc_pkg::DP_LOAD_K:
					k <= k_next;
				lpc_pkg::DP_UPD_ERR:
					err <= product;
				default:
				begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- levinson/recursion_fsm.sv
// Levinson recursion sequencer
`timescale 1ns/100ps
`default_nettype none

module recursion_fsm
(
	input logic clk,
	input logic rst,
	input logic start,
	input lpc_pkg::autocorr_t autocorr,
	input lpc_pkg::fix_t rd_a_val,
	input lpc_pkg::fix_t rd_b_val,
	input lpc_pkg::fix_t acc,
	input lpc_pkg::fix_t k,
	input lpc_pkg::fix_t err,
	input lpc_pkg::fix_t mac_result,
	input lpc_pkg::fix_t quotient,
	input logic div_done,
	output lpc_pkg::idx_t rd_a,
	output lpc_pkg::idx_t rd_b,
	output logic wr_en,
	output lpc_pkg::idx_t wr_idx,
	output lpc_pkg::fix_t wr_data,
	output logic swap,
	output logic clear,
	output lpc_pkg::dp_cmd_t dp_cmd,
	output logic div_start,
	output lpc_pkg::fix_t div_num,
	output lpc_pkg::fix_t div_den,
	output lpc_pkg::lpc_word_t lpc_out,
	output logic done
);

	typedef enum logic [3:0]
	{
		S_IDLE,
		S_CLEAR,
		S_SUM,
		S_DIV,
		S_WAIT,
		S_SETK,
		S_UPD,
		S_KK,
		S_ERR,
		S_OUT,
		S_GAP
	} state_t;

	state_t state;

	// i is the order, j walks the coefficients
	lpc_pkg::idx_t i;
	lpc_pkg::idx_t j;
	lpc_pkg::idx_t lag;

	assign lag = i - j;

	// acc holds R[i] + sum once the accumulate loop is over
	assign div_num = acc;
	assign div_den = err;

	// ------------------------------------------------------------------------
	// command decode
	// ------------------------------------------------------------------------

	always_comb
	begin
		rd_a = j;
		rd_b = lag;
		wr_en = 1'b0;
		wr_idx = j;
		wr_data = mac_result;
		swap = 1'b0;
		clear = 1'b0;
		div_start = 1'b0;
		dp_cmd.op = lpc_pkg::DP_NONE;
		dp_cmd.lhs = '0;
		dp_cmd.rhs = '0;
		case (state)
			S_IDLE:
			begin
				// new frame: empty bank, err preset from R0
				if (start)
				begin
					clear = 1'b1;
					dp_cmd.op = lpc_pkg::DP_CLEAR;
					dp_cmd.lhs = autocorr[0];
				end
			end
			S_CLEAR:
			begin
				dp_cmd.op = lpc_pkg::DP_CLEAR;
				dp_cmd.lhs = err;
			end
			S_SUM:
			begin
				// a[0] is 1.0, so the j = 0 term brings in R[i]
				dp_cmd.op = lpc_pkg::DP_ACC;
				dp_cmd.lhs = (j == '0) ? lpc_pkg::FIX_ONE : rd_a_val;
				dp_cmd.rhs = autocorr[lag];
			end
			S_DIV:
			begin
				div_start = 1'b1;
			end
			S_WAIT:
			begin
				if (div_done)
				begin
					dp_cmd.op = lpc_pkg::DP_LOAD_K;
					dp_cmd.lhs = quotient;
				end
			end
			S_SETK:
			begin
				// a_new[i] = k, acc freed for k * k
				wr_en = 1'b1;
				wr_idx = i;
				wr_data = k;
				dp_cmd.op = lpc_pkg::DP_CLEAR;
				dp_cmd.lhs = err;
			end
			S_UPD:
			begin
				wr_en = 1'b1;
				dp_cmd.op = lpc_pkg::DP_UPD_COEF;
				dp_cmd.lhs = rd_a_val;
				dp_cmd.rhs = rd_b_val;
			end
			S_KK:
			begin
				dp_cmd.op = lpc_pkg::DP_ACC;
				dp_cmd.lhs = k;
				dp_cmd.rhs = k;
			end
			S_ERR:
			begin
				dp_cmd.op = lpc_pkg::DP_UPD_ERR;
				swap = 1'b1;
			end
			default:
			begin
			end
		endcase
	end

	// ------------------------------------------------------------------------
	// state and counters
	// ------------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= S_IDLE;
			i <= '0;
			j <= '0;
			lpc_out <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			lpc_out.we <= 1'b0;
			case (state)
				S_IDLE:
				begin
					if (start)
					begin
						i <= lpc_pkg::idx_t'(1);
						j <= '0;
						state <= S_SUM;
					end
				end
				S_CLEAR:
				begin
					j <= '0;
					state <= S_SUM;
				end
				S_SUM:
				begin
					if (j == i - 1'b1)
						state <= S_DIV;
					else
						j <= j + 1'b1;
				end
				S_DIV:
					state <= S_WAIT;
				S_WAIT:
				begin
					if (div_done)
						state <= S_SETK;
				end
				S_SETK:
				begin
					j <= lpc_pkg::idx_t'(1);
					// order 1 has no older coefficients to update
					state <= (i == lpc_pkg::idx_t'(1)) ? S_KK : S_UPD;
				end
				S_UPD:
				begin
					if (j == i - 1'b1)
						state <= S_KK;
					else
						j <= j + 1'b1;
				end
				S_KK:
					state <= S_ERR;
				S_ERR:
				begin
					if (i == lpc_pkg::idx_t'(lpc_pkg::ORDER))
					begin
						j <= '0;
						state <= S_OUT;
					end
					else
					begin
						i <= i + 1'b1;
						state <= S_CLEAR;
					end
				end
				S_OUT:
				begin
					lpc_out.we <= 1'b1;
					lpc_out.addr <= j;
					lpc_out.value <= (j == '0) ? lpc_pkg::FIX_ONE : rd_a_val;
					state <= S_GAP;
				end
				S_GAP:
				begin
					if (j == lpc_pkg::idx_t'(lpc_pkg::ORDER))
					begin
						done <= 1'b1;
						state <= S_IDLE;
					end
					else
					begin
						j <= j + 1'b1;
						state <= S_OUT;
					end
				end
				default:
					state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- levinson/coef_bank.sv
// Ping-pong coefficient bank
`timescale 1ns/100ps
`default_nettype none

module coef_bank
(
	input logic clk,
	input logic rst,
	input logic clear,
	input logic swap,
	input logic wr_en,
	input lpc_pkg::idx_t wr_idx,
	input lpc_pkg::fix_t wr_data,
	input lpc_pkg::idx_t rd_a,
	input lpc_pkg::idx_t rd_b,
	output lpc_pkg::fix_t rd_a_val,
	output lpc_pkg::fix_t rd_b_val
);

	lpc_pkg::fix_t bank0 [0:lpc_pkg::ORDER];
	lpc_pkg::fix_t bank1 [0:lpc_pkg::ORDER];

	// sel low: bank0 is old, bank1 is new
	logic sel;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			sel <= 1'b0;
		else if (clear)
			sel <= 1'b0;
		else if (swap)
			sel <= ~sel;
	end

	always_ff @(posedge clk)
	begin
		if (clear)
		begin
			for (int n = 0; n <= lpc_pkg::ORDER; n++)
			begin
				bank0[n] <= '0;
				bank1[n] <= '0;
			end
		end
		else if (wr_en)
		begin
			// writes always land in the new array
			if (sel)
				bank0[wr_idx] <= wr_data;
			else
				bank1[wr_idx] <= wr_data;
		end
	end

	assign rd_a_val = sel ? bank1[rd_a] : bank0[rd_a];
	assign rd_b_val = sel ? bank1[rd_b] : bank0[rd_b];

endmodule

`default_nettype wire

//--- common/lpc_pkg.sv
// LPC recursion shared definitions
`default_nettype none

package lpc_pkg;

	// ------------------------------------------------------------------------
	// sizes
	// ------------------------------------------------------------------------

	// predictor order, lags 0 to ORDER
	localparam int ORDER = 10;

	// fixed point is signed two's complement, 16 fraction bits
	localparam int FRAC_BITS = 16;
	localparam int FIX_WIDTH = 34;

	// divider works on the numerator scaled by 2^FRAC_BITS
	localparam int DIV_WIDTH = 50;

	localparam int IDX_WIDTH = 4;

	// ------------------------------------------------------------------------
	// types
	// ------------------------------------------------------------------------

	typedef logic signed [FIX_WIDTH-1:0] fix_t;
	typedef logic [IDX_WIDTH-1:0] idx_t;

	// 1.0 in fix_t
	localparam fix_t FIX_ONE = fix_t'(1 << FRAC_BITS);

	// autocorrelation frame, element n is lag n
	typedef fix_t [ORDER:0] autocorr_t;

	// one word of the coefficient stream
	typedef struct packed
	{
		logic we;
		idx_t addr;
		fix_t value;
	} lpc_word_t;

	// datapath operations
	typedef enum logic [2:0]
	{
		DP_NONE,
		DP_CLEAR,
		DP_ACC,
		DP_LOAD_K,
		DP_UPD_COEF,
		DP_UPD_ERR
	} dp_op_t;

	typedef struct packed
	{
		dp_op_t op;
		fix_t lhs;
		fix_t rhs;
	} dp_cmd_t;

endpackage

`default_nettype wire
